//--- common/raycast_macros.svh
`ifndef RAYCAST_MACROS_SVH
`define RAYCAST_MACROS_SVH

// number of screen columns walked per frame
`define RAY_SCREEN_WIDTH 320

// fraction bits of the q8.8 format
`define RAY_FRAC_BITS 8

// ray job fifo entries
`define RAY_FIFO_DEPTH 16

// camera plane scale
// column * 410 >> 8 is close to 2 * column / 320
// subtract 1.0 afterwards to get the offset in -1..+1
`define RAY_CAM_SCALE 410

`endif

//--- common/raycast_pkg.sv
package raycast_pkg;

    // ************************************************************
    // fixed point and index types
    // ************************************************************

    // signed q8.8, 8 integer bits and 8 fraction bits
    typedef logic signed [15:0] fixed_t;

    // screen column, 0 to 319
    typedef logic [8:0] column_t;

    // index into the test pose table
    typedef logic [2:0] pose_sel_t;

    // ************************************************************
    // camera pose and ray job
    // ************************************************************

    // one full camera pose
    typedef struct packed {
        fixed_t pos_x;
        fixed_t pos_y;
        fixed_t dir_x;
        fixed_t dir_y;
        fixed_t plane_x;
        fixed_t plane_y;
    } pose_t;

    // one ray job for the wall tracer, 43 bits
    // step bits set means step in the negative direction
    typedef struct packed {
        column_t column;
        logic    step_x;
        logic    step_y;
        fixed_t  ray_dir_x;
        fixed_t  ray_dir_y;
    } ray_job_t;

endpackage

//--- common/camera_if.sv
`timescale 1ns/1ps

interface camera_if;
    import raycast_pkg::*;

    // player position, q8.8
    fixed_t pos_x;
    fixed_t pos_y;
    // view direction
    fixed_t dir_x;
    fixed_t dir_y;
    // camera plane, perpendicular to dir
    fixed_t plane_x;
    fixed_t plane_y;

    // pose table side
    modport source (output pos_x, pos_y, dir_x, dir_y, plane_x, plane_y);

    // ray setup side
    modport sink (input pos_x, pos_y, dir_x, dir_y, plane_x, plane_y);

endinterface

//--- hw/pose_table.sv
`timescale 1ns/1ps

module pose_table (
    input  logic                  clk_pixel,
    input  logic                  sys_rst,
    input  raycast_pkg::pose_sel_t pose_sel,
    camera_if.source              cam
);
    import raycast_pkg::*;

    // ************************************************************
    // pose lookup
    // ************************************************************

    // eight switch test poses, q8.8
    // 0b80 = 11.5, 1480 = 20.5, 0480 = 4.5
    // 00b5/ff4b = +/-0.707, 0077/ff89 = +/-0.465, 00a9/ff57 = +/-0.66
    function automatic pose_t pose_lookup(input pose_sel_t sel);
        pose_t p;
        case (sel)
            // looking along +x
            3'd0: p = '{16'h0b80, 16'h0b80, 16'h0100, 16'h0000, 16'h0000, 16'h00a9};
            // 45 deg into +x +y
            3'd1: p = '{16'h0b80, 16'h0b80, 16'h00b5, 16'h00b5, 16'hff89, 16'h0077};
            // looking along +y
            3'd2: p = '{16'h0b80, 16'h0b80, 16'h0000, 16'h0100, 16'hff57, 16'h0000};
            // 45 deg into -x +y
            3'd3: p = '{16'h0b80, 16'h0b80, 16'hff4b, 16'h00b5, 16'hff89, 16'hff89};
            // near the corner at 20.5, 4.5
            3'd4: p = '{16'h1480, 16'h0480, 16'h00b5, 16'h00b5, 16'hff89, 16'h0077};
            3'd5: p = '{16'h0480, 16'h0480, 16'hff4b, 16'h00b5, 16'hff89, 16'hff89};
            3'd6: p = '{16'h0480, 16'h1480, 16'h00b5, 16'h00b5, 16'hff89, 16'h0077};
            default: begin
                // pose 7, far corner
                p = '{16'h1480, 16'h1480, 16'hff4b, 16'h00b5, 16'hff89, 16'hff89};
            end
        endcase
        return p;
    endfunction

    // ************************************************************
    // registered output
    // ************************************************************

    pose_t pose_q;

    // one cycle from pose_sel to the bus
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            // hold the default view in reset
            pose_q <= pose_lookup(3'd0);
        end else begin
            pose_q <= pose_lookup(pose_sel);
        end
    end

    // drive the camera bus
    assign cam.pos_x   = pose_q.pos_x;
    assign cam.pos_y   = pose_q.pos_y;
    assign cam.dir_x   = pose_q.dir_x;
    assign cam.dir_y   = pose_q.dir_y;
    assign cam.plane_x = pose_q.plane_x;
    assign cam.plane_y = pose_q.plane_y;

endmodule

//--- ray_setup/ray_setup.sv
`timescale 1ns/1ps

`include "raycast_macros.svh"

module ray_setup (
    input  logic                  clk_pixel,
    input  logic                  sys_rst,
    camera_if.sink                cam,
    output logic                  out_valid,
    input  logic                  out_ready,
    output raycast_pkg::ray_job_t out_job
);
    import raycast_pkg::*;

    // 1.0 in q8.8
    localparam fixed_t ONE = fixed_t'(1 << `RAY_FRAC_BITS);

    // pipeline control
    logic    s1_valid;
    logic    s2_valid;
    logic    s3_valid;
    logic    advance;
    column_t col_cnt;

    // output stage full and not taken, everything holds
    assign advance = !(s3_valid && !out_ready);

    // ************************************************************
    // stage 1, column issue and camera offset
    // ************************************************************

    logic [17:0] col_scaled;
    fixed_t      col_offset;

    // offset = (col * scale >> frac) - 1.0
    assign col_scaled = 18'(col_cnt) * 18'(`RAY_CAM_SCALE);
    assign col_offset = fixed_t'(16'(col_scaled >> `RAY_FRAC_BITS)) - ONE;

    column_t s1_column;
    fixed_t  s1_offset;
    // frame pose, only reloaded at column 0
    fixed_t  s1_dir_x;
    fixed_t  s1_dir_y;
    fixed_t  s1_plane_x;
    fixed_t  s1_plane_y;

    // column counter, wraps after the last screen column
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            col_cnt <= '0;
        end else if (advance) begin
            if (col_cnt == column_t'(`RAY_SCREEN_WIDTH - 1)) begin
                col_cnt <= '0;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (advance) begin
            s1_column <= col_cnt;
            s1_offset <= col_offset;
            // new pose only at frame start
            if (col_cnt == '0) begin
                s1_dir_x   <= cam.dir_x;
                s1_dir_y   <= cam.dir_y;
                s1_plane_x <= cam.plane_x;
                s1_plane_y <= cam.plane_y;
            end
        end
    end

    // ************************************************************
    // stage 2, plane times offset
    // ************************************************************

    logic signed [31:0] plane_prod_x;
    logic signed [31:0] plane_prod_y;

    // q8.8 * q8.8 gives q16.16
    assign plane_prod_x = s1_plane_x * s1_offset;
    assign plane_prod_y = s1_plane_y * s1_offset;

    column_t s2_column;
    fixed_t  s2_dir_x;
    fixed_t  s2_dir_y;
    fixed_t  s2_term_x;
    fixed_t  s2_term_y;

    always_ff @(posedge clk_pixel) begin
        if (advance) begin
            s2_column <= s1_column;
            s2_dir_x  <= s1_dir_x;
            s2_dir_y  <= s1_dir_y;
            // back to q8.8, sign kept
            s2_term_x <= 16'(plane_prod_x >>> `RAY_FRAC_BITS);
            s2_term_y <= 16'(plane_prod_y >>> `RAY_FRAC_BITS);
        end
    end

    // ************************************************************
    // stage 3, ray direction and step signs
    // ************************************************************

    fixed_t ray_x;
    fixed_t ray_y;

    assign ray_x = s2_dir_x + s2_term_x;
    assign ray_y = s2_dir_y + s2_term_y;

    always_ff @(posedge clk_pixel) begin
        if (advance) begin
            out_job.column    <= s2_column;
            // sign bit, 1 means step negative
            out_job.step_x    <= ray_x[15];
            out_job.step_y    <= ray_y[15];
            out_job.ray_dir_x <= ray_x;
            out_job.ray_dir_y <= ray_y;
        end
    end

    // stage valids, stage 1 issues every cycle it may
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= 1'b1;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    assign out_valid = s3_valid;

endmodule

//--- hw/ray_job_fifo.sv
`timescale 1ns/1ps

`include "raycast_macros.svh"

module ray_job_fifo (
    input  logic                  clk_pixel,
    input  logic                  sys_rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  raycast_pkg::ray_job_t in_job,
    output logic                  out_valid,
    input  logic                  out_ready,
    output raycast_pkg::ray_job_t out_job
);
    import raycast_pkg::*;

    localparam int unsigned DEPTH = `RAY_FIFO_DEPTH;
    localparam int unsigned AW    = $clog2(DEPTH);

    // storage, no reset needed
    ray_job_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    // flags from occupancy
    assign in_ready  = (count != (AW+1)'(DEPTH));
    assign out_valid = (count != '0);

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // show-ahead read port
    assign out_job = mem[rd_ptr];

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_job;
        end
    end

    // pointers wrap at DEPTH
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // both at once leaves count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hw/raycast_front_top.sv
`timescale 1ns/1ps

module raycast_front_top (
    input  logic                   clk_pixel,
    input  logic                   sys_rst,
    input  raycast_pkg::pose_sel_t pose_sel,
    input  logic                   job_ready,
    output logic                   job_valid,
    output raycast_pkg::column_t   job_column,
    output logic                   job_step_x,
    output logic                   job_step_y,
    output raycast_pkg::fixed_t    job_ray_dir_x,
    output raycast_pkg::fixed_t    job_ray_dir_y,
    output raycast_pkg::fixed_t    cam_pos_x,
    output raycast_pkg::fixed_t    cam_pos_y
);
    import raycast_pkg::*;

    // ************************************************************
    // pose table to ray setup
    // ************************************************************

    camera_if cam_bus ();

    pose_table u_pose_table (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .pose_sel  (pose_sel),
        .cam       (cam_bus.source)
    );

    // ray setup into the job queue
    logic     setup_valid;
    logic     setup_ready;
    ray_job_t setup_job;
    ray_job_t fifo_job;

    ray_setup u_ray_setup (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .cam       (cam_bus.sink),
        .out_valid (setup_valid),
        .out_ready (setup_ready),
        .out_job   (setup_job)
    );

    ray_job_fifo u_ray_job_fifo (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .in_valid  (setup_valid),
        .in_ready  (setup_ready),
        .in_job    (setup_job),
        .out_valid (job_valid),
        .out_ready (job_ready),
        .out_job   (fifo_job)
    );

    // ************************************************************
    // unpack for the wall tracer
    // ************************************************************

    assign job_column    = fifo_job.column;
    assign job_step_x    = fifo_job.step_x;
    assign job_step_y    = fifo_job.step_y;
    assign job_ray_dir_x = fifo_job.ray_dir_x;
    assign job_ray_dir_y = fifo_job.ray_dir_y;

    // current pose position, straight off the bus
    assign cam_pos_x = cam_bus.pos_x;
    assign cam_pos_y = cam_bus.pos_y;

endmodule

//--- verification/raycast_front_tb.sv
`timescale 1ns/1ps

`include "raycast_macros.svh"

module raycast_front_tb;
    import raycast_pkg::*;

    localparam int MAX_VEC    = 64;
    localparam int MAX_FRAMES = 8;
    localparam int WIDTH      = `RAY_SCREEN_WIDTH;

    // dut ports
    logic      clk_pixel;
    logic      sys_rst;
    pose_sel_t pose_sel;
    logic      job_ready;
    logic      job_valid;
    column_t   job_column;
    logic      job_step_x;
    logic      job_step_y;
    fixed_t    job_ray_dir_x;
    fixed_t    job_ray_dir_y;
    fixed_t    cam_pos_x;
    fixed_t    cam_pos_y;

    // vector table with one entry per checked job
    string       vec_name [MAX_VEC];
    int          vec_frame [MAX_VEC];
    int          vec_col [MAX_VEC];
    logic [15:0] vec_rx [MAX_VEC];
    logic [15:0] vec_ry [MAX_VEC];
    int          vec_sx [MAX_VEC];
    int          vec_sy [MAX_VEC];
    int          num_vec;

    // pose of each frame and its table position
    int          frame_pose [MAX_FRAMES];
    logic [15:0] frame_px [MAX_FRAMES];
    logic [15:0] frame_py [MAX_FRAMES];
    int          num_frames;

    int tests_passed;
    int tests_failed;
    int load_errs;
    int cycle_count = 0;
    int cycle_limit = 200;

    raycast_front_top u_raycast_front_top (
        .clk_pixel     (clk_pixel),
        .sys_rst       (sys_rst),
        .pose_sel      (pose_sel),
        .job_ready     (job_ready),
        .job_valid     (job_valid),
        .job_column    (job_column),
        .job_step_x    (job_step_x),
        .job_step_y    (job_step_y),
        .job_ray_dir_x (job_ray_dir_x),
        .job_ray_dir_y (job_ray_dir_y),
        .cam_pos_x     (cam_pos_x),
        .cam_pos_y     (cam_pos_y)
    );

    // 40 ns pixel clock
    always #20 clk_pixel = ~clk_pixel;

    // run limit is set once the vectors are known
    always @(posedge clk_pixel) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped delivering jobs", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ************************************************************
    // checking helpers
    // ************************************************************

    task automatic check_value(input string test_name, input string field,
                               input logic [15:0] expected, input logic [15:0] actual,
                               inout int errs);
        if (actual !== expected) begin
            $display("error %s %s expected %h actual %h", test_name, field, expected, actual);
            errs = errs + 1;
        end
    endtask

    task automatic finish_test(input string test_name, input int errs);
        if (errs == 0) begin
            tests_passed = tests_passed + 1;
            $display("test %s passed", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d mismatches", test_name, errs);
        end
    endtask

    // accepted job against one vector line
    task automatic compare_vector(input int i);
        int errs;
        errs = 0;
        check_value(vec_name[i], "ray_dir_x", vec_rx[i], job_ray_dir_x, errs);
        check_value(vec_name[i], "ray_dir_y", vec_ry[i], job_ray_dir_y, errs);
        check_value(vec_name[i], "step_x", 16'(vec_sx[i]), 16'(job_step_x), errs);
        check_value(vec_name[i], "step_y", 16'(vec_sy[i]), 16'(job_step_y), errs);
        finish_test(vec_name[i], errs);
    endtask

    // ************************************************************
    // vector file
    // ************************************************************

    task automatic load_vectors();
        int          fd;
        int          n;
        int          frame;
        int          pose_v;
        int          col_v;
        int          sx_v;
        int          sy_v;
        string       line;
        string       name_v;
        logic [15:0] rx_v;
        logic [15:0] ry_v;
        logic [15:0] px_v;
        logic [15:0] py_v;
        num_vec = 0;
        num_frames = 0;
        frame = 0;
        fd = $fopen("verification/ray_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/ray_vectors.txt");
            load_errs = load_errs + 1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // comment lines start with #
            if (line.len() == 0 || line.getc(0) == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %h %h %d %d %h %h", name_v, pose_v, col_v,
                        rx_v, ry_v, sx_v, sy_v, px_v, py_v);
            if (n <= 0) begin
                continue;
            end
            if (n != 9 || num_vec >= MAX_VEC) begin
                $display("skipped a malformed or surplus vector line: %s", line);
                load_errs = load_errs + 1;
                continue;
            end
            // column not above the last one means the next frame
            if (num_vec > 0 && col_v <= vec_col[num_vec - 1]) begin
                frame = frame + 1;
            end
            if (frame >= MAX_FRAMES) begin
                $display("vector file holds more frames than the testbench tracks");
                load_errs = load_errs + 1;
                break;
            end
            if (frame == num_frames) begin
                frame_pose[frame] = pose_v;
                frame_px[frame] = px_v;
                frame_py[frame] = py_v;
                num_frames = frame + 1;
            end
            vec_name[num_vec] = name_v;
            vec_frame[num_vec] = frame;
            vec_col[num_vec] = col_v;
            vec_rx[num_vec] = rx_v;
            vec_ry[num_vec] = ry_v;
            vec_sx[num_vec] = sx_v;
            vec_sy[num_vec] = sy_v;
            num_vec = num_vec + 1;
        end
        $fclose(fd);
        // 16 cycles per job to cover heavy back-pressure
        if (num_vec > 0) begin
            cycle_limit = 16 * (vec_frame[num_vec - 1] * WIDTH + vec_col[num_vec - 1] + 1)
                          + 200;
        end
    endtask

    // ************************************************************
    // reset and job stream
    // ************************************************************

    task automatic run_jobs();
        int    vi;
        int    frame;
        int    exp_col;
        int    next_f;
        int    seq_errs;
        int    reset_errs;
        int    pos_errs;
        string pos_name;
        vi = 0;
        frame = 0;
        exp_col = 0;
        seq_errs = 0;
        reset_errs = 0;
        // four reset edges with valid low after the first
        @(posedge clk_pixel);
        repeat (3) begin
            @(posedge clk_pixel);
            check_value("reset", "job_valid", 16'h0000, 16'(job_valid), reset_errs);
        end
        sys_rst <= 1'b0;
        while (vi < num_vec) begin
            // ready high about three cycles in four
            job_ready <= (($urandom % 4) != 0);
            @(posedge clk_pixel);
            if (job_valid && job_ready) begin
                if (frame == 0 && exp_col == 0) begin
                    check_value("reset", "first column", 16'h0000, 16'(job_column), reset_errs);
                    finish_test("reset", reset_errs);
                end
                check_value("column_sequence", "column", 16'(exp_col), 16'(job_column),
                            seq_errs);
                if (vec_frame[vi] == frame && vec_col[vi] == exp_col) begin
                    compare_vector(vi);
                    vi = vi + 1;
                end
                // next frame pose is switched mid-frame
                next_f = (frame + 1 < num_frames) ? frame + 1 : frame;
                if (exp_col == 100) begin
                    pose_sel <= pose_sel_t'(frame_pose[next_f]);
                end
                // position follows pose_sel long before column 200
                if (exp_col == 200) begin
                    pos_errs = 0;
                    pos_name = $sformatf("cam_pos_f%0d_pose%0d", frame, frame_pose[next_f]);
                    check_value(pos_name, "cam_pos_x", frame_px[next_f], cam_pos_x, pos_errs);
                    check_value(pos_name, "cam_pos_y", frame_py[next_f], cam_pos_y, pos_errs);
                    finish_test(pos_name, pos_errs);
                end
                if (exp_col == WIDTH - 1) begin
                    exp_col = 0;
                    frame = frame + 1;
                end else begin
                    exp_col = exp_col + 1;
                end
            end
        end
        finish_test("column_sequence", seq_errs);
    endtask

    initial begin
        clk_pixel = 1'b0;
        sys_rst = 1'b1;
        pose_sel = '0;
        job_ready = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        load_errs = 0;
        void'($urandom(32'hfd6e_f4f5));
        load_vectors();
        if (num_vec > 0) begin
            run_jobs();
        end else begin
            $display("no test vectors were loaded, nothing was checked");
        end
        $display("tests run %0d, passed %0d, failed %0d, vector file errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, load_errs);
        if (tests_failed == 0 && load_errs == 0 && tests_passed > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/ray_vectors.txt
# name pose column ray_dir_x ray_dir_y step_x step_y pos_x pos_y
# ray_dir and pos in hex q8.8, a column not above the previous one starts the next frame
f0_p0_c000 0 0   0100 ff57 0 1 0b80 0b80
f0_p0_c001 0 1   0100 ff57 0 1 0b80 0b80
f0_p0_c080 0 80  0100 ffab 0 1 0b80 0b80
f0_p0_c160 0 160 0100 0000 0 0 0b80 0b80
f0_p0_c240 0 240 0100 0054 0 0 0b80 0b80
f0_p0_c319 0 319 0100 00a7 0 0 0b80 0b80
f1_p3_c000 3 0   ffc2 012c 1 0 0b80 0b80
f1_p3_c080 3 80  ff86 00f0 1 0 0b80 0b80
f1_p3_c160 3 160 ff4b 00b5 1 0 0b80 0b80
f1_p3_c240 3 240 ff0f 0079 1 0 0b80 0b80
f1_p3_c319 3 319 fed4 003e 1 0 0b80 0b80
f2_p7_c000 7 0   ffc2 012c 1 0 1480 1480
f2_p7_c160 7 160 ff4b 00b5 1 0 1480 1480
f2_p7_c319 7 319 fed4 003e 1 0 1480 1480
f3_p4_c000 4 0   012c 003e 0 0 1480 0480
f3_p4_c080 4 80  00f0 0079 0 0 1480 0480
f3_p4_c160 4 160 00b5 00b5 0 0 1480 0480
f3_p4_c319 4 319 003e 012b 0 0 1480 0480

//--- compile.f
+incdir+common
common/raycast_pkg.sv
common/camera_if.sv
hw/pose_table.sv
ray_setup/ray_setup.sv
hw/ray_job_fifo.sv
hw/raycast_front_top.sv
verification/raycast_front_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module raycast_front_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vraycast_front_tb); echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
